//--- oh_link_config.svh
`ifndef OH_LINK_CONFIG_SVH
`define OH_LINK_CONFIG_SVH

// request port
`define OH_ADDR_W    16
`define OH_DATA_W    32

// e-link word and delay line
`define OH_WORD_W    8
`define OH_TAP_W     6   // 64 stage line
`define OH_FRAME_LEN 14  // hdr + 4 addr + 8 data + csum

// apb register map, byte offsets
`define OH_APB_AW    5
`define OH_APB_DW    32
`define OH_REG_TAP   5'h00
`define OH_REG_TXINV 5'h04
`define OH_REG_RXINV 5'h08
`define OH_REG_GOOD  5'h0C
`define OH_REG_BAD   5'h10

`endif

//--- oh_link_pkg.sv
`default_nettype none

package oh_link_pkg;

  // ------------------------------
  // framer
  // ------------------------------
  typedef enum logic {
    TX_IDLE, // idle words, ttc bits only
    TX_SEND  // 14 nibbles on the wire
  } tx_state_e;

  // ------------------------------
  // decoder
  // ------------------------------
  typedef enum logic {
    RX_HUNT,   // waiting for frame start
    RX_COLLECT // gathering nibbles
  } rx_state_e;

  // ------------------------------
  // apb register select
  // ------------------------------
  typedef enum logic [2:0] {
    REG_TAP,
    REG_TXINV,
    REG_RXINV,
    REG_GOOD,
    REG_BAD,
    REG_NONE // unmapped offset
  } reg_sel_e;

endpackage

`default_nettype wire

//--- oh_link_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "oh_link_config.svh"

module oh_link_regs (
  input  wire                   clk40,
  input  wire                   arst_n_i,
  input  wire                   psel_i,
  input  wire                   penable_i,
  input  wire                   pwrite_i,
  input  wire [`OH_APB_AW-1:0]  paddr_i,
  input  wire [`OH_APB_DW-1:0]  pwdata_i,
  input  wire                   frame_good_i,
  input  wire                   frame_bad_i,
  output logic [`OH_APB_DW-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic [`OH_TAP_W-1:0]  tap_o,
  output logic [`OH_WORD_W-1:0] tx_invert_o,
  output logic [`OH_WORD_W-1:0] rx_invert_o
);

  localparam int CNT_W = 16; // frame counter width

  oh_link_pkg::reg_sel_e sel;
  logic                  access;     // apb access phase
  logic                  wr_en;
  logic [CNT_W-1:0]      good_cnt_q;
  logic [CNT_W-1:0]      bad_cnt_q;

  // ------------------------------
  // address decode
  // ------------------------------
  always_comb begin
    case (paddr_i)
      `OH_REG_TAP:   sel = oh_link_pkg::REG_TAP;
      `OH_REG_TXINV: sel = oh_link_pkg::REG_TXINV;
      `OH_REG_RXINV: sel = oh_link_pkg::REG_RXINV;
      `OH_REG_GOOD:  sel = oh_link_pkg::REG_GOOD;
      `OH_REG_BAD:   sel = oh_link_pkg::REG_BAD;
      default:       sel = oh_link_pkg::REG_NONE;
    endcase
  end

  assign access   = psel_i && penable_i;
  assign wr_en    = access && pwrite_i;
  assign pready_o = 1'b1; // no wait states

  // unmapped offset, or counters are read only
  assign pslverr_o = access && ((sel == oh_link_pkg::REG_NONE) ||
                                (pwrite_i && (sel == oh_link_pkg::REG_GOOD ||
                                              sel == oh_link_pkg::REG_BAD)));

  // config registers, written in access phase
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tap_o       <= '0;
      tx_invert_o <= '0;
      rx_invert_o <= '0;
    end else if (wr_en) begin
      case (sel)
        oh_link_pkg::REG_TAP:   tap_o       <= pwdata_i[`OH_TAP_W-1:0];
        oh_link_pkg::REG_TXINV: tx_invert_o <= pwdata_i[`OH_WORD_W-1:0];
        oh_link_pkg::REG_RXINV: rx_invert_o <= pwdata_i[`OH_WORD_W-1:0];
        default: ; // counters and holes ignore writes
      endcase
    end
  end

  // ------------------------------
  // saturating frame counters
  // ------------------------------
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      good_cnt_q <= '0;
      bad_cnt_q  <= '0;
    end else begin
      if (frame_good_i && !(&good_cnt_q)) good_cnt_q <= good_cnt_q + 1'b1;
      if (frame_bad_i && !(&bad_cnt_q))   bad_cnt_q  <= bad_cnt_q + 1'b1;
    end
  end

  // read mux, zero extended
  always_comb begin
    prdata_o = '0;
    case (sel)
      oh_link_pkg::REG_TAP:   prdata_o[`OH_TAP_W-1:0]  = tap_o;
      oh_link_pkg::REG_TXINV: prdata_o[`OH_WORD_W-1:0] = tx_invert_o;
      oh_link_pkg::REG_RXINV: prdata_o[`OH_WORD_W-1:0] = rx_invert_o;
      oh_link_pkg::REG_GOOD:  prdata_o[CNT_W-1:0]      = good_cnt_q;
      oh_link_pkg::REG_BAD:   prdata_o[CNT_W-1:0]      = bad_cnt_q;
      default:                prdata_o                 = '0;
    endcase
  end

  // master protocol: enable only inside a selected transfer
  a_penable_sel: assert property (@(posedge clk40) disable iff (!arst_n_i)
    penable_i |-> psel_i);

endmodule

`default_nettype wire

//--- oh_link_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "oh_link_config.svh"

module oh_link_tx (
  input  wire                   clk40,
  input  wire                   arst_n_i,
  input  wire                   req_valid_i,
  input  wire                   req_write_i,
  input  wire [`OH_ADDR_W-1:0]  req_addr_i,
  input  wire [`OH_DATA_W-1:0]  req_data_i,
  input  wire                   l1a_i,
  input  wire                   bc0_i,
  input  wire                   resync_i,
  output logic                  busy_o,
  output logic [`OH_WORD_W-1:0] elink_data_o
);

  localparam int         NIB_W     = 4;
  localparam int         PAY_W     = `OH_ADDR_W + `OH_DATA_W; // 12 nibbles
  localparam logic [3:0] LAST_NIB  = 4'(`OH_FRAME_LEN - 1);  // checksum slot
  localparam logic [3:0] LAST_DATA = LAST_NIB - 4'd1;

  oh_link_pkg::tx_state_e state_q;
  logic [3:0]             nib_cnt_q; // index of next nibble on the wire
  logic [PAY_W-1:0]       pay_q;     // addr then data, msn first
  logic                   wr_q;
  logic [NIB_W-1:0]       csum_q;    // running mod-16 sum
  logic [NIB_W-1:0]       nib_cur;
  logic                   accept;

  assign accept = req_valid_i && !busy_o;

  // nibble for the current slot
  always_comb begin
    if (nib_cnt_q == 4'd0)
      nib_cur = {3'b000, wr_q}; // header
    else if (nib_cnt_q == LAST_NIB)
      nib_cur = csum_q;
    else
      nib_cur = pay_q[PAY_W-1 -: NIB_W];
  end

  // ------------------------------
  // control fsm
  // ------------------------------
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= oh_link_pkg::TX_IDLE;
      nib_cnt_q <= '0;
      busy_o    <= 1'b0;
    end else if (accept) begin // also on the checksum slot, back to back
      state_q   <= oh_link_pkg::TX_SEND;
      nib_cnt_q <= '0;
      busy_o    <= 1'b1;
    end else if (state_q == oh_link_pkg::TX_SEND) begin
      nib_cnt_q <= nib_cnt_q + 4'd1;
      if (nib_cnt_q == LAST_DATA) busy_o <= 1'b0; // free one word early
      if (nib_cnt_q == LAST_NIB) begin
        state_q   <= oh_link_pkg::TX_IDLE;
        nib_cnt_q <= '0;
      end
    end
  end

  // request latch, shifter and checksum
  always_ff @(posedge clk40) begin
    if (accept) begin
      pay_q <= {req_addr_i, req_data_i};
      wr_q  <= req_write_i;
    end else if (state_q == oh_link_pkg::TX_SEND && nib_cnt_q != 4'd0 &&
                 nib_cnt_q != LAST_NIB) begin
      pay_q <= pay_q << NIB_W;
    end
    if (state_q == oh_link_pkg::TX_SEND)
      csum_q <= (nib_cnt_q == 4'd0) ? nib_cur : csum_q + nib_cur;
  end

  // ------------------------------
  // e-link word
  // ------------------------------
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      elink_data_o <= '0;
    end else begin
      elink_data_o[7:5] <= {l1a_i, bc0_i, resync_i}; // ttc rides every word
      if (state_q == oh_link_pkg::TX_SEND) begin
        elink_data_o[4]   <= (nib_cnt_q == 4'd0); // frame start on header
        elink_data_o[3:0] <= nib_cur;
      end else begin
        elink_data_o[4:0] <= '0; // idle
      end
    end
  end

  a_nib_cnt_range: assert property (@(posedge clk40) disable iff (!arst_n_i)
    nib_cnt_q < 4'(`OH_FRAME_LEN));

endmodule

`default_nettype wire

//--- oh_link_delay.sv
`timescale 1ns/1ps
`default_nettype none
`include "oh_link_config.svh"

module oh_link_delay (
  input  wire                  clk40,
  input  wire                  arst_n_i,
  input  wire                  ce_i,
  input  wire [`OH_TAP_W-1:0]  tap_i,
  input  wire [`OH_WORD_W-1:0] invert_i,
  input  wire [`OH_WORD_W-1:0] word_i,
  output wire [`OH_WORD_W-1:0] word_o
);

  localparam int DEPTH = 2 ** `OH_TAP_W; // 64 stages per lane

  // ------------------------------
  // one shift line per e-link bit
  // ------------------------------
  genvar lane;
  for (lane = 0; lane < `OH_WORD_W; lane = lane + 1) begin : g_lane
    logic [DEPTH-1:0] line_q;

    // empty line after reset, no stale frame starts
    always_ff @(posedge clk40 or negedge arst_n_i) begin
      if (!arst_n_i)
        line_q <= '0;
      else if (ce_i)
        line_q <= {line_q[DEPTH-2:0], word_i[lane]}; // stage 0 is newest
    end

    // tap select then lane polarity swap
    assign word_o[lane] = line_q[tap_i] ^ invert_i[lane];
  end

endmodule

`default_nettype wire

//--- oh_link_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "oh_link_config.svh"

module oh_link_rx (
  input  wire                   clk40,
  input  wire                   arst_n_i,
  input  wire  [`OH_WORD_W-1:0] word_i,
  input  wire  [`OH_WORD_W-1:0] invert_i,
  output logic                  rx_l1a_o,
  output logic                  rx_bc0_o,
  output logic                  rx_resync_o,
  output logic                  rx_valid_o,
  output logic                  rx_write_o,
  output logic [`OH_ADDR_W-1:0] rx_addr_o,
  output logic [`OH_DATA_W-1:0] rx_data_o,
  output logic                  rx_error_o
);

  localparam int         NIB_W    = 4;
  localparam int         PAY_W    = `OH_ADDR_W + `OH_DATA_W;
  localparam logic [3:0] LAST_NIB = 4'(`OH_FRAME_LEN - 1); // checksum slot

  oh_link_pkg::rx_state_e state_q;
  logic [`OH_WORD_W-1:0]  word;    // after local polarity undo
  logic [NIB_W-1:0]       nib;
  logic                   fstart;
  logic [3:0]             cnt_q;   // slot of the incoming nibble
  logic [NIB_W-1:0]       csum_q;
  logic [PAY_W-1:0]       pay_q;
  logic                   wr_q;    // header bit 0
  logic                   last_slot;

  assign word      = word_i ^ invert_i;
  assign nib       = word[3:0];
  assign fstart    = word[4];
  assign last_slot = (state_q == oh_link_pkg::RX_COLLECT) && !fstart &&
                     (cnt_q == LAST_NIB);

  // ttc bits straight to pulses
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_l1a_o    <= 1'b0;
      rx_bc0_o    <= 1'b0;
      rx_resync_o <= 1'b0;
    end else begin
      rx_l1a_o    <= word[7];
      rx_bc0_o    <= word[6];
      rx_resync_o <= word[5];
    end
  end

  // ------------------------------
  // frame fsm
  // ------------------------------
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= oh_link_pkg::RX_HUNT;
      cnt_q      <= '0;
      rx_valid_o <= 1'b0;
      rx_error_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0; // single cycle pulses
      rx_error_o <= 1'b0;
      case (state_q)
        oh_link_pkg::RX_HUNT: begin
          if (fstart) begin
            state_q <= oh_link_pkg::RX_COLLECT;
            cnt_q   <= 4'd1;
          end
        end
        oh_link_pkg::RX_COLLECT: begin
          if (fstart) begin // restart, old frame lost
            cnt_q      <= 4'd1;
            rx_error_o <= 1'b1;
          end else if (cnt_q == LAST_NIB) begin
            state_q    <= oh_link_pkg::RX_HUNT;
            cnt_q      <= '0;
            rx_valid_o <= (nib == csum_q);
            rx_error_o <= (nib != csum_q);
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
        default: state_q <= oh_link_pkg::RX_HUNT;
      endcase
    end
  end

  // nibble gather and checksum
  always_ff @(posedge clk40) begin
    if (fstart) begin
      csum_q <= nib; // header opens the sum
      wr_q   <= nib[0];
    end else if (state_q == oh_link_pkg::RX_COLLECT && cnt_q != LAST_NIB) begin
      csum_q <= csum_q + nib;
      pay_q  <= {pay_q[PAY_W-NIB_W-1:0], nib}; // msn first
    end
    if (last_slot) begin
      rx_write_o <= wr_q;
      rx_addr_o  <= pay_q[PAY_W-1 -: `OH_ADDR_W];
      rx_data_o  <= pay_q[`OH_DATA_W-1:0];
    end
  end

  a_valid_error_excl: assert property (@(posedge clk40) disable iff (!arst_n_i)
    !(rx_valid_o && rx_error_o));

endmodule

`default_nettype wire

//--- oh_link_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "oh_link_config.svh"

module oh_link_top (
  input  wire                   clk40,
  input  wire                   arst_n_i,
  // request port
  input  wire                   req_valid_i,
  input  wire                   req_write_i,
  input  wire [`OH_ADDR_W-1:0]  req_addr_i,
  input  wire [`OH_DATA_W-1:0]  req_data_i,
  output wire                   busy_o,
  // ttc
  input  wire                   l1a_i,
  input  wire                   bc0_i,
  input  wire                   resync_i,
  // apb
  input  wire                   psel_i,
  input  wire                   penable_i,
  input  wire                   pwrite_i,
  input  wire [`OH_APB_AW-1:0]  paddr_i,
  input  wire [`OH_APB_DW-1:0]  pwdata_i,
  output wire [`OH_APB_DW-1:0]  prdata_o,
  output wire                   pready_o,
  output wire                   pslverr_o,
  // recovered side
  output wire                   rx_l1a_o,
  output wire                   rx_bc0_o,
  output wire                   rx_resync_o,
  output wire                   rx_valid_o,
  output wire                   rx_write_o,
  output wire [`OH_ADDR_W-1:0]  rx_addr_o,
  output wire [`OH_DATA_W-1:0]  rx_data_o,
  output wire                   rx_error_o
);

  wire [`OH_WORD_W-1:0] tx_word;   // framer to link
  wire [`OH_WORD_W-1:0] dly_word;  // link to decoder
  wire [`OH_TAP_W-1:0]  tap;
  wire [`OH_WORD_W-1:0] tx_invert;
  wire [`OH_WORD_W-1:0] rx_invert;

  // ------------------------------
  // framer
  // ------------------------------
  oh_link_tx oh_link_tx_inst (
    .clk40        (clk40),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_data_i   (req_data_i),
    .l1a_i        (l1a_i),
    .bc0_i        (bc0_i),
    .resync_i     (resync_i),
    .busy_o       (busy_o),
    .elink_data_o (tx_word)
  );

  // link emulator, always shifting
  oh_link_delay oh_link_delay_inst (
    .clk40    (clk40),
    .arst_n_i (arst_n_i),
    .ce_i     (1'b1),
    .tap_i    (tap),
    .invert_i (tx_invert),
    .word_i   (tx_word),
    .word_o   (dly_word)
  );

  // ------------------------------
  // decoder
  // ------------------------------
  oh_link_rx oh_link_rx_inst (
    .clk40       (clk40),
    .arst_n_i    (arst_n_i),
    .word_i      (dly_word),
    .invert_i    (rx_invert),
    .rx_l1a_o    (rx_l1a_o),
    .rx_bc0_o    (rx_bc0_o),
    .rx_resync_o (rx_resync_o),
    .rx_valid_o  (rx_valid_o),
    .rx_write_o  (rx_write_o),
    .rx_addr_o   (rx_addr_o),
    .rx_data_o   (rx_data_o),
    .rx_error_o  (rx_error_o)
  );

  // config and frame statistics
  oh_link_regs oh_link_regs_inst (
    .clk40        (clk40),
    .arst_n_i     (arst_n_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .frame_good_i (rx_valid_o), // checksum ok
    .frame_bad_i  (rx_error_o),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .tap_o        (tap),
    .tx_invert_o  (tx_invert),
    .rx_invert_o  (rx_invert)
  );

endmodule

`default_nettype wire

//--- oh_link_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "oh_link_config.svh"

module oh_link_tb;

  localparam int N_FRAMES     = 40 + 12 + 20 + 3 * 8;
  localparam int WATCHDOG_CYC = N_FRAMES * (63 + 30) + 2000; // sized for the deepest tap

  typedef struct packed {
    logic        ok;   // checksum holds after the rx mask
    logic        wr;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] due;  // cycle count when the rx pulse shows
  } exp_frame_t;

  logic                   clk40;
  logic                   arst_n_i;
  logic                   req_valid_i;
  logic                   req_write_i;
  logic [`OH_ADDR_W-1:0]  req_addr_i;
  logic [`OH_DATA_W-1:0]  req_data_i;
  logic                   l1a_i;
  logic                   bc0_i;
  logic                   resync_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [`OH_APB_AW-1:0]  paddr_i;
  logic [`OH_APB_DW-1:0]  pwdata_i;
  wire                    busy_o;
  wire  [`OH_APB_DW-1:0]  prdata_o;
  wire                    pready_o;
  wire                    pslverr_o;
  wire                    rx_l1a_o;
  wire                    rx_bc0_o;
  wire                    rx_resync_o;
  wire                    rx_valid_o;
  wire                    rx_write_o;
  wire  [`OH_ADDR_W-1:0]  rx_addr_o;
  wire  [`OH_DATA_W-1:0]  rx_data_o;
  wire                    rx_error_o;

  // model state
  int          cyc = 0;                          // rising edges seen so far
  int          tap_m = 0;
  logic [7:0]  tx_m = 8'h00;
  logic [7:0]  rx_m = 8'h00;
  int          good_m = 0;
  int          bad_m = 0;
  int          busy_end = 0;                     // first cycle with busy_o low again
  logic [2:0]  hist [128] = '{default: 3'b000}; // ttc inputs by cycle
  exp_frame_t  exp_q [$];
  logic        ttc_en;                           // ttc generator on
  logic        ttc_chk;                          // off while masks move
  logic [31:0] lfsr_main = 32'h5d1f;
  logic [31:0] lfsr_ttc = 32'h5d1f;

  oh_link_top oh_link_top_inst (.*);

  initial begin
    clk40 = 1'b0;
    forever #50 clk40 = ~clk40; // 100 ns period
  end

  always @(posedge clk40) cyc <= cyc + 1;

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic fail_now(input string msg);
    $display("FAIL @ %0d ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hA300_0000; // x^32+x^30+x^26+x^25+1
    return s >> 1;
  endfunction

  task automatic draw(inout logic [31:0] st, input int nbits, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < nbits; i++) begin
      st = lfsr_step(st); // one step per bit
      v  = {v[30:0], st[0]};
    end
  endtask

  // mod-16 sum of the 13 frame nibbles, each xored with x
  function automatic logic [3:0] nib_sum(input logic wr, input logic [15:0] a,
                                         input logic [31:0] d, input logic [3:0] x);
    logic [3:0]  s;
    logic [15:0] aa;
    logic [31:0] dd;
    int          i;
    s  = {3'b000, wr} ^ x; // header
    aa = a;
    dd = d;
    for (i = 0; i < 4; i++) begin
      s  = s + (aa[15:12] ^ x);
      aa = aa << 4;
    end
    for (i = 0; i < 8; i++) begin
      s  = s + (dd[31:28] ^ x);
      dd = dd << 4;
    end
    return s;
  endfunction

  // ------------------------------
  // apb driver
  // ------------------------------
  task automatic apb_access(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    @(posedge clk40);
    psel_i    <= 1'b1; // setup phase
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk40);
    penable_i <= 1'b1; // access phase
    @(negedge clk40);
    rdata  = prdata_o;
    slverr = pslverr_o;
    assert (pready_o) else fail_now("pready_o low in the access phase");
    @(posedge clk40);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    assert (!err) else fail_now($sformatf("pslverr on write to 0x%02h", addr));
  endtask

  task automatic check_reg(input logic [4:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, 32'h0, rd, err);
    assert (!err && rd == exp)
      else fail_now($sformatf("read 0x%02h gave 0x%08h err %0b, want 0x%08h",
                              addr, rd, err, exp));
  endtask

  task automatic write_expect_error(input logic [4:0] addr);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, 32'hFFFF_FFFF, rd, err);
    assert (err) else fail_now($sformatf("no pslverr on write to 0x%02h", addr));
  endtask

  task automatic check_counts();
    check_reg(`OH_REG_GOOD, 32'(good_m));
    check_reg(`OH_REG_BAD, 32'(bad_m));
  endtask

  // ------------------------------
  // request side
  // ------------------------------
  task automatic send_req(input logic w, input logic [15:0] a, input logic [31:0] d);
    req_valid_i <= 1'b1; // held until taken
    req_write_i <= w;
    req_addr_i  <= a;
    req_data_i  <= d;
    @(negedge clk40);
    while (busy_o) @(negedge clk40);
    @(posedge clk40); // accepting edge
    req_valid_i <= 1'b0;
  endtask

  task automatic send_burst(input int n);
    logic [31:0] r_w;
    logic [31:0] r_a;
    logic [31:0] r_d;
    logic [31:0] r_g;
    int          i;
    int          g;
    for (i = 0; i < n; i++) begin
      draw(lfsr_main, 1, r_w);
      draw(lfsr_main, 16, r_a);
      draw(lfsr_main, 32, r_d);
      draw(lfsr_main, 3, r_g);
      send_req(r_w[0], r_a[15:0], r_d);
      g = int'(r_g[2:0]);
      if (g > 4) g = 0; // back to back about half the time
      repeat (g) @(posedge clk40);
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk40);
    @(posedge clk40);
  endtask

  // link must sit idle a full line depth before the tap moves
  task automatic configure(input int tap, input logic [7:0] txm, input logic [7:0] rxm);
    ttc_en <= 1'b0;
    wait_drain();
    repeat (70) @(posedge clk40);
    ttc_chk = 1'b0; // masks disagree between the two writes
    write_reg(`OH_REG_TAP, 32'(tap));
    write_reg(`OH_REG_TXINV, {24'h0, txm});
    write_reg(`OH_REG_RXINV, {24'h0, rxm});
    tap_m = tap;
    tx_m  = txm;
    rx_m  = rxm;
    repeat (4) @(posedge clk40);
    ttc_chk = 1'b1;
  endtask

  // ttc pulse generator, own lfsr stream
  initial begin : ttc_driver
    logic [31:0] r;
    l1a_i    = 1'b0;
    bc0_i    = 1'b0;
    resync_i = 1'b0;
    forever begin
      @(posedge clk40);
      if (ttc_en) begin
        draw(lfsr_ttc, 9, r);
        l1a_i    <= &r[2:0]; // one in eight per line
        bc0_i    <= &r[5:3];
        resync_i <= &r[8:6];
      end else begin
        l1a_i    <= 1'b0;
        bc0_i    <= 1'b0;
        resync_i <= 1'b0;
      end
    end
  end

  // ------------------------------
  // model and checks, on the falling edge
  // ------------------------------
  always @(negedge clk40) begin : monitor
    exp_frame_t acc_e;
    exp_frame_t got_e;
    logic [3:0] diff;
    logic [6:0] hidx;
    if (arst_n_i) begin
      assert (busy_o == (cyc < busy_end))
        else fail_now($sformatf("busy_o %0b at cycle %0d, want %0b",
                                busy_o, cyc, cyc < busy_end));
      if (req_valid_i && !busy_o) begin // taken at the next edge
        busy_end   = cyc + 14; // busy from the taking edge, next take 14 edges on
        diff       = tx_m[3:0] ^ rx_m[3:0];
        acc_e.ok   = nib_sum(req_write_i, req_addr_i, req_data_i, diff) ==
                     (nib_sum(req_write_i, req_addr_i, req_data_i, 4'h0) ^ diff);
        acc_e.wr   = req_write_i ^ diff[0];
        acc_e.addr = req_addr_i ^ {4{diff}};
        acc_e.data = req_data_i ^ {8{diff}};
        acc_e.due  = 32'(cyc + tap_m + 17);
        exp_q.push_back(acc_e);
      end
      if (rx_valid_o || rx_error_o) begin
        assert (exp_q.size() != 0) else fail_now("frame pulse with no request in flight");
        got_e = exp_q.pop_front();
        assert (32'(cyc) == got_e.due)
          else fail_now($sformatf("frame pulse at cycle %0d, want %0d", cyc, got_e.due));
        if (got_e.ok) begin
          assert (rx_valid_o && !rx_error_o && rx_write_o == got_e.wr &&
                  rx_addr_o == got_e.addr && rx_data_o == got_e.data)
            else fail_now($sformatf(
              "rx v%0b e%0b w%0b a %04h d %08h, want w%0b a %04h d %08h",
              rx_valid_o, rx_error_o, rx_write_o, rx_addr_o, rx_data_o,
              got_e.wr, got_e.addr, got_e.data));
          good_m = good_m + 1;
        end else begin
          assert (rx_error_o && !rx_valid_o)
            else fail_now("frame with bad checksum not flagged as error");
          bad_m = bad_m + 1;
        end
      end else if (exp_q.size() != 0) begin
        assert (32'(cyc) < exp_q[0].due)
          else fail_now($sformatf("frame pulse missing, due at cycle %0d", exp_q[0].due));
      end
      if (ttc_chk) begin
        hidx = 7'(cyc - tap_m - 3); // ttc latency tap + 3
        assert ({rx_l1a_o, rx_bc0_o, rx_resync_o} == hist[hidx])
          else fail_now($sformatf("ttc out %03b, want %03b",
                                  {rx_l1a_o, rx_bc0_o, rx_resync_o}, hist[hidx]));
      end
    end
    hist[7'(cyc)] = {l1a_i, bc0_i, resync_i};
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk40);
    $display("watchdog: run went past %0d cycles, the DUT stopped answering", WATCHDOG_CYC);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin : main
    logic [31:0] r;
    logic [31:0] m;
    logic [31:0] dv;
    logic [7:0]  mt;
    int          k;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_data_i  = '0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    arst_n_i    = 1'b0;
    ttc_en      = 1'b0;
    ttc_chk     = 1'b0;
    repeat (2) @(posedge clk40);
    arst_n_i <= 1'b1;
    repeat (3) @(posedge clk40);

    // state after reset
    @(negedge clk40);
    assert (!busy_o && !rx_valid_o && !rx_error_o && !rx_l1a_o && !rx_bc0_o && !rx_resync_o)
      else fail_now("outputs not idle after reset");
    check_reg(`OH_REG_TAP, 32'h0);
    check_reg(`OH_REG_TXINV, 32'h0);
    check_reg(`OH_REG_RXINV, 32'h0);
    check_counts();
    ttc_chk = 1'b1;

    // equal masks, frames only
    draw(lfsr_main, 6, r);
    draw(lfsr_main, 7, m);
    mt = {m[6:4], 1'b0, m[3:0]}; // frame start lane left alone
    configure(int'(r[5:0]), mt, mt);
    send_burst(40);
    wait_drain();
    check_counts();

    // ttc pulses alone, then over frames
    ttc_en <= 1'b1;
    repeat (60) @(posedge clk40);
    send_burst(12);
    wait_drain();
    check_counts();

    // rx mask off by a payload nibble
    draw(lfsr_main, 6, r);
    draw(lfsr_main, 7, m);
    draw(lfsr_main, 4, dv);
    if (dv[3:0] == 4'h0) dv[3:0] = 4'h5;
    mt = {m[6:4], 1'b0, m[3:0]};
    configure(int'(r[5:0]), mt, mt ^ {4'h0, dv[3:0]});
    ttc_en <= 1'b1;
    send_burst(20);
    wait_drain();
    check_counts();

    // slave errors, counters stay put
    write_expect_error(5'h14);
    write_expect_error(5'h1F);
    write_expect_error(`OH_REG_GOOD);
    write_expect_error(`OH_REG_BAD);
    check_counts();

    // three taps in turn
    for (k = 0; k < 3; k++) begin
      draw(lfsr_main, 6, r);
      draw(lfsr_main, 7, m);
      mt = {m[6:4], 1'b0, m[3:0]};
      configure(int'(r[5:0]), mt, mt);
      check_reg(`OH_REG_TAP, 32'(tap_m));
      ttc_en <= 1'b1;
      send_burst(8);
      wait_drain();
      check_counts();
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
oh_link_pkg.sv
oh_link_regs.sv
oh_link_tx.sv
oh_link_delay.sv
oh_link_rx.sv
oh_link_top.sv
oh_link_tb.sv

//--- run.sh
#!/bin/sh
# build and run the oh_link testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module oh_link_tb \
  -Mdir obj_dir -o oh_link_sim -f sources.f || exit 1
./obj_dir/oh_link_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }
